/* rhPkg.sv */
// Field types, register offsets, CS1 and CS2 bit positions, drive function codes
`default_nettype none

package rhPkg;

   ////////////////////////////////////////////////////////////
   // Field types
   ////////////////////////////////////////////////////////////

   // One 16-bit register word
   typedef logic [15:0] rhWordT;
   // Adapter data bus, big-endian 0:35 numbering
   typedef logic [0:35] devDataT;
   // Register offset inside the block
   typedef logic [2:0] rhRegAddrT;
   // Drive function, held in CS1 bits 5:1
   typedef logic [4:0] rpFunT;
   // Drive unit select
   typedef logic [2:0] rhUnitT;

   // Register offsets, others read as zero
   localparam rhRegAddrT rhAddrCs1 = 3'd0;
   localparam rhRegAddrT rhAddrBa  = 3'd1;
   localparam rhRegAddrT rhAddrCs2 = 3'd2;

   // CS1 layout
   localparam int cs1BitGo   = 0;
   localparam int cs1FunLo   = 1;
   localparam int cs1BitIe   = 6;
   localparam int cs1BitRdy  = 7;
   // Low bit of BA extension field 9:8
   localparam int cs1BaExt   = 8;
   localparam int cs1BitPsel = 10;
   localparam int cs1BitDva  = 11;
   localparam int cs1BitCpe  = 13;
   localparam int cs1BitTre  = 14;
   localparam int cs1BitSc   = 15;

   // CS2 layout
   localparam int cs2UnitLo = 0;
   localparam int cs2BitClr = 5;
   localparam int cs2BitPge = 10;
   localparam int cs2BitNed = 12;

   // Function codes
   localparam rpFunT funNop        = 5'd0;
   localparam rpFunT funDriveClear = 5'd4;
   // Codes at or above this end with drive error
   localparam rpFunT funIllegalMin = 5'd28;

endpackage

`default_nettype wire

/* rhCs1.sv */
// CS1 register with TRE edge latch, PSEL and IE bits and word assembly
`timescale 1ns/1ps
`default_nettype none

module rhCs1 (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 devRESET,
   input  wire                 devLOBYTE,
   input  wire                 devHIBYTE,
   input  wire rhPkg::devDataT devDATAI,
   input  wire                 rhcs1WRITE,
   input  wire                 rhCLRGO,
   input  wire                 rhCLRTRE,
   input  wire                 rhPGE,
   input  wire                 rhNED,
   input  wire                 rhCLR,
   input  wire                 rhIACK,
   input  wire                 rpATA,
   input  wire                 rpERR,
   input  wire                 rpDVA,
   input  wire rhPkg::rpFunT   rpFUN,
   input  wire                 rpGO,
   input  wire [1:0]           rhBA,
   output rhPkg::rhWordT       rhCS1
);

   import rhPkg::*;

   logic [35:0] dataLe;
   logic        statTre;
   logic        lastTre;
   logic        cs1Tre;
   logic        cs1Cpe;
   logic        cs1Rdy;
   logic        cs1Psel;
   logic        cs1Ie;
   logic        cs1Sc;

   // Swap bus to little-endian
   assign dataLe = devDATAI;

   ////////////////////////////////////////////////////////////
   // Transfer error
   ////////////////////////////////////////////////////////////

   // Composite error, other controller errors tied off
   assign statTre = rhNED | rhPGE | rpERR;

   always_ff @(posedge clk)
   begin
      if (rst)
         lastTre <= 1'b0;
      else
         lastTre <= statTre;
   end

   // Set on rising edge only
   always_ff @(posedge clk)
   begin
      if (rst || devRESET || rhCLR || rhCLRTRE || rhCLRGO)
         cs1Tre <= 1'b0;
      else if (statTre && !lastTre)
         cs1Tre <= 1'b1;
   end

   // No Massbus parity here
   assign cs1Cpe = 1'b0;

   // Ready whenever drive idle
   assign cs1Rdy = !rpGO;

   // Port select, high byte, only when ready
   always_ff @(posedge clk)
   begin
      if (rst || devRESET || rhCLR)
         cs1Psel <= 1'b0;
      else if (rhcs1WRITE && devHIBYTE && cs1Rdy)
         cs1Psel <= dataLe[cs1BitPsel];
   end

   // Interrupt enable, low byte; acknowledge drops it
   always_ff @(posedge clk)
   begin
      if (rst || devRESET || rhCLR || rhIACK)
         cs1Ie <= 1'b0;
      else if (rhcs1WRITE && devLOBYTE)
         cs1Ie <= dataLe[cs1BitIe];
   end

   assign cs1Sc = cs1Tre | cs1Cpe | rpATA;

   ////////////////////////////////////////////////////////////
   // Word assembly
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      rhCS1                 = '0;
      rhCS1[cs1BitSc]       = cs1Sc;
      rhCS1[cs1BitTre]      = cs1Tre;
      rhCS1[cs1BitCpe]      = cs1Cpe;
      rhCS1[cs1BitDva]      = rpDVA;
      rhCS1[cs1BitPsel]     = cs1Psel;
      rhCS1[cs1BaExt +: 2]  = rhBA;
      rhCS1[cs1BitRdy]      = cs1Rdy;
      rhCS1[cs1BitIe]       = cs1Ie;
      rhCS1[cs1FunLo +: 5]  = rpFUN;
      rhCS1[cs1BitGo]       = rpGO;
   end

endmodule

`default_nettype wire

/* rhCs2.sv */
// CS2 register with unit select, controller clear pulse and NED and PGE error latches
`timescale 1ns/1ps
`default_nettype none

module rhCs2 (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 devRESET,
   input  wire                 devLOBYTE,
   input  wire rhPkg::devDataT devDATAI,
   input  wire                 rhcs2WRITE,
   input  wire                 goReject,
   input  wire                 goWhileBusy,
   input  wire                 rhCLRGO,
   input  wire                 rhCLRTRE,
   output rhPkg::rhWordT       rhCS2,
   output rhPkg::rhUnitT       rhUnit,
   output logic                rhCLR,
   output logic                rhNED,
   output logic                rhPGE
);

   import rhPkg::*;

   logic [35:0] dataLe;
   logic        lowWrite;
   logic        errClear;

   // Swap bus to little-endian
   assign dataLe = devDATAI;

   // Low byte write to CS2
   assign lowWrite = rhcs2WRITE & devLOBYTE;

   ////////////////////////////////////////////////////////////
   // Controller clear
   ////////////////////////////////////////////////////////////

   // One cycle wide, follows the write strobe
   // Never stored, so CLR reads back 0
   assign rhCLR = lowWrite & dataLe[cs2BitClr];

   ////////////////////////////////////////////////////////////
   // Unit select
   ////////////////////////////////////////////////////////////

   // Clear wins over a unit load in the same write
   always_ff @(posedge clk)
   begin
      if (rst || devRESET || rhCLR)
         rhUnit <= '0;
      else if (lowWrite)
         rhUnit <= dataLe[cs2UnitLo +: 3];
   end

   ////////////////////////////////////////////////////////////
   // Error latches
   ////////////////////////////////////////////////////////////

   // Shared clear term for NED and PGE
   assign errClear = rst | devRESET | rhCLR | rhCLRTRE | rhCLRGO;

   // Non-existent drive
   // GO issued with no drive at selected unit
   always_ff @(posedge clk)
   begin
      if (errClear)
         rhNED <= 1'b0;
      else if (goReject)
         rhNED <= 1'b1;
   end

   // Program error
   // GO issued while drive still busy
   always_ff @(posedge clk)
   begin
      if (errClear)
         rhPGE <= 1'b0;
      else if (goWhileBusy)
         rhPGE <= 1'b1;
   end

   // Word assembly, unused bits read zero
   always_comb
   begin
      rhCS2                  = '0;
      rhCS2[cs2BitNed]       = rhNED;
      rhCS2[cs2BitPge]       = rhPGE;
      rhCS2[cs2UnitLo +: 3]  = rhUnit;
   end

endmodule

`default_nettype wire

/* rhBa.sv */
// Bus address register with word-aligned address and CS1-loaded extension bits
`timescale 1ns/1ps
`default_nettype none

module rhBa (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 devRESET,
   input  wire                 devLOBYTE,
   input  wire                 devHIBYTE,
   input  wire rhPkg::devDataT devDATAI,
   input  wire                 rhbaWRITE,
   input  wire                 rhcs1WRITE,
   input  wire                 rhCLR,
   input  wire                 rpGO,
   output rhPkg::rhWordT       rhBaWord,
   output logic [1:0]          rhBA
);

   import rhPkg::*;

   logic [35:0] dataLe;
   // Bit 0 not stored, always even
   logic [15:1] baAddr;

   // Swap bus to little-endian
   assign dataLe = devDATAI;

   // Address, byte lanes independent
   always_ff @(posedge clk)
   begin
      if (rst || devRESET || rhCLR)
         baAddr <= '0;
      else if (rhbaWRITE)
      begin
         if (devLOBYTE)
            baAddr[7:1] <= dataLe[7:1];
         if (devHIBYTE)
            baAddr[15:8] <= dataLe[15:8];
      end
   end

   // Extension bits, CS1 high byte, locked while busy
   always_ff @(posedge clk)
   begin
      if (rst || devRESET || rhCLR)
         rhBA <= '0;
      else if (rhcs1WRITE && devHIBYTE && !rpGO)
         rhBA <= dataLe[cs1BaExt +: 2];
   end

   assign rhBaWord = {baAddr, 1'b0};

endmodule

`default_nettype wire

/* rhDrive.sv */
// Single drive model with function latch, GO timing, attention, error and drive available
`timescale 1ns/1ps
`default_nettype none

module rhDrive #(
   parameter int driveLatency = 16
) (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 devRESET,
   input  wire                 devLOBYTE,
   input  wire rhPkg::devDataT devDATAI,
   input  wire                 rhcs1WRITE,
   input  wire                 rhCLR,
   input  wire rhPkg::rhUnitT  rhUnit,
   output logic                rpGO,
   output rhPkg::rpFunT        rpFUN,
   output logic                rpDVA,
   output logic                rpATA,
   output logic                rpERR,
   output logic                goReject,
   output logic                goWhileBusy
);

   import rhPkg::*;

   typedef enum logic {driveIdle, driveBusy} driveStateT;

   // Counter holds latency minus one
   localparam int cntW = $clog2(driveLatency);

   logic [35:0]     dataLe;
   logic            goWrite;
   rpFunT           newFun;
   driveStateT      state;
   logic [cntW-1:0] cnt;

   // Swap bus to little-endian
   assign dataLe  = devDATAI;
   assign newFun  = dataLe[cs1FunLo +: 5];
   assign goWrite = rhcs1WRITE & devLOBYTE & dataLe[cs1BitGo];

   // Only unit 0 answers
   assign rpDVA = (rhUnit == '0);
   assign rpGO  = (state == driveBusy);

   always_ff @(posedge clk)
   begin
      // Reject pulses last one cycle
      goReject    <= 1'b0;
      goWhileBusy <= 1'b0;
      if (rst || devRESET || rhCLR)
      begin
         state <= driveIdle;
         cnt   <= '0;
         rpFUN <= funNop;
         rpATA <= 1'b0;
         rpERR <= 1'b0;
      end
      else
      begin
         // Count down, finish with attention
         if (state == driveBusy)
         begin
            if (cnt == '0)
            begin
               state <= driveIdle;
               rpATA <= 1'b1;
               if (rpFUN >= funIllegalMin)
                  rpERR <= 1'b1;
            end
            else
               cnt <= cnt - cntW'(1);
         end
         // GO handling
         if (goWrite)
         begin
            if (!rpDVA)
               goReject <= 1'b1;
            else if (state == driveBusy)
               goWhileBusy <= 1'b1;
            else if (newFun == funDriveClear)
            begin
               // Drive clear, no busy period
               rpFUN <= newFun;
               rpATA <= 1'b0;
               rpERR <= 1'b0;
            end
            else
            begin
               state <= driveBusy;
               cnt   <= cntW'(driveLatency - 1);
               rpFUN <= newFun;
               rpATA <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rhUnibusSlave.sv */
// Bus front end with address decode, write strobes, registered read mux and interrupt request
`timescale 1ns/1ps
`default_nettype none

module rhUnibusSlave (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   devRESET,
   input  wire                   devWRITE,
   input  wire                   devREAD,
   input  wire                   devHIBYTE,
   input  wire rhPkg::rhRegAddrT devADDR,
   input  wire rhPkg::devDataT   devDATAI,
   input  wire rhPkg::rhWordT    rhCS1,
   input  wire rhPkg::rhWordT    rhBaWord,
   input  wire rhPkg::rhWordT    rhCS2,
   input  wire                   rhIACK,
   output logic                  rhcs1WRITE,
   output logic                  rhbaWRITE,
   output logic                  rhcs2WRITE,
   output logic                  rhCLRTRE,
   output logic                  rhCLRGO,
   output rhPkg::devDataT        devDATAO,
   output logic                  devACK,
   output logic                  intReq
);

   import rhPkg::*;

   logic [35:0] dataLe;
   rhWordT      readMux;
   rhWordT      readData;
   logic        lastRdy;
   logic        lastSc;
   logic        intEvent;

   // Swap bus to little-endian
   assign dataLe = devDATAI;

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////

   assign rhcs1WRITE = devWRITE & (devADDR == rhAddrCs1);
   assign rhbaWRITE  = devWRITE & (devADDR == rhAddrBa);
   assign rhcs2WRITE = devWRITE & (devADDR == rhAddrCs2);

   // TRE clear from high byte bit 14
   assign rhCLRTRE = rhcs1WRITE & devHIBYTE & dataLe[cs1BitTre];
   // GO sits in the low byte
   assign rhCLRGO  = rhcs1WRITE & dataLe[cs1BitGo];

   // Read mux, unmapped offsets give zero
   always_comb
   begin
      case (devADDR)
         rhAddrCs1: readMux = rhCS1;
         rhAddrBa:  readMux = rhBaWord;
         rhAddrCs2: readMux = rhCS2;
         default:   readMux = '0;
      endcase
   end

   // Data held until next read
   always_ff @(posedge clk)
   begin
      if (devREAD)
         readData <= readMux;
   end

   always_ff @(posedge clk)
   begin
      if (rst || devRESET)
         devACK <= 1'b0;
      else
         devACK <= devREAD;
   end

   // Register value in low 16 bits, 20:35
   assign devDATAO = {20'b0, readData};

   ////////////////////////////////////////////////////////////
   // Interrupt request
   ////////////////////////////////////////////////////////////

   // RDY is set out of reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         lastRdy <= 1'b1;
         lastSc  <= 1'b0;
      end
      else
      begin
         lastRdy <= rhCS1[cs1BitRdy];
         lastSc  <= rhCS1[cs1BitSc];
      end
   end

   // Rising RDY or SC with IE set
   assign intEvent = rhCS1[cs1BitIe] &
                     ((rhCS1[cs1BitRdy] & !lastRdy) | (rhCS1[cs1BitSc] & !lastSc));

   always_ff @(posedge clk)
   begin
      if (rst || devRESET || rhIACK)
         intReq <= 1'b0;
      else if (intEvent)
         intReq <= 1'b1;
   end

endmodule

`default_nettype wire

/* rhController.sv */
// Controller top level connecting bus front end, CS1, CS2, BA and drive model
`timescale 1ns/1ps
`default_nettype none

module rhController #(
   parameter int driveLatency = 16
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   devRESET,
   input  wire                   devWRITE,
   input  wire                   devREAD,
   input  wire                   devHIBYTE,
   input  wire                   devLOBYTE,
   input  wire rhPkg::rhRegAddrT devADDR,
   input  wire rhPkg::devDataT   devDATAI,
   input  wire                   rhIACK,
   output rhPkg::devDataT        devDATAO,
   output logic                  devACK,
   output logic                  intReq,
   output rhPkg::rhWordT         rhCS1
);

   import rhPkg::*;

   // Write strobes and clears
   logic        rhcs1WRITE;
   logic        rhbaWRITE;
   logic        rhcs2WRITE;
   logic        rhCLRTRE;
   logic        rhCLRGO;
   logic        rhCLR;
   // Register words and fields
   rhWordT      rhCS2;
   rhWordT      rhBaWord;
   logic [1:0]  rhBA;
   rhUnitT      rhUnit;
   logic        rhNED;
   logic        rhPGE;
   // Drive status
   logic        rpGO;
   rpFunT       rpFUN;
   logic        rpDVA;
   logic        rpATA;
   logic        rpERR;
   logic        goReject;
   logic        goWhileBusy;

   rhUnibusSlave uSlave (
      .clk(clk), .rst(rst), .devRESET(devRESET), .devWRITE(devWRITE),
      .devREAD(devREAD), .devHIBYTE(devHIBYTE), .devADDR(devADDR),
      .devDATAI(devDATAI), .rhCS1(rhCS1), .rhBaWord(rhBaWord), .rhCS2(rhCS2),
      .rhIACK(rhIACK), .rhcs1WRITE(rhcs1WRITE), .rhbaWRITE(rhbaWRITE),
      .rhcs2WRITE(rhcs2WRITE), .rhCLRTRE(rhCLRTRE), .rhCLRGO(rhCLRGO),
      .devDATAO(devDATAO), .devACK(devACK), .intReq(intReq)
   );

   rhCs1 uCs1 (
      .clk(clk), .rst(rst), .devRESET(devRESET), .devLOBYTE(devLOBYTE),
      .devHIBYTE(devHIBYTE), .devDATAI(devDATAI), .rhcs1WRITE(rhcs1WRITE),
      .rhCLRGO(rhCLRGO), .rhCLRTRE(rhCLRTRE), .rhPGE(rhPGE), .rhNED(rhNED),
      .rhCLR(rhCLR), .rhIACK(rhIACK), .rpATA(rpATA), .rpERR(rpERR),
      .rpDVA(rpDVA), .rpFUN(rpFUN), .rpGO(rpGO), .rhBA(rhBA), .rhCS1(rhCS1)
   );

   rhCs2 uCs2 (
      .clk(clk), .rst(rst), .devRESET(devRESET), .devLOBYTE(devLOBYTE),
      .devDATAI(devDATAI), .rhcs2WRITE(rhcs2WRITE), .goReject(goReject),
      .goWhileBusy(goWhileBusy), .rhCLRGO(rhCLRGO), .rhCLRTRE(rhCLRTRE),
      .rhCS2(rhCS2), .rhUnit(rhUnit), .rhCLR(rhCLR), .rhNED(rhNED), .rhPGE(rhPGE)
   );

   rhBa uBa (
      .clk(clk), .rst(rst), .devRESET(devRESET), .devLOBYTE(devLOBYTE),
      .devHIBYTE(devHIBYTE), .devDATAI(devDATAI), .rhbaWRITE(rhbaWRITE),
      .rhcs1WRITE(rhcs1WRITE), .rhCLR(rhCLR), .rpGO(rpGO),
      .rhBaWord(rhBaWord), .rhBA(rhBA)
   );

   rhDrive #(
      .driveLatency(driveLatency)
   ) uDrive (
      .clk(clk), .rst(rst), .devRESET(devRESET), .devLOBYTE(devLOBYTE),
      .devDATAI(devDATAI), .rhcs1WRITE(rhcs1WRITE), .rhCLR(rhCLR),
      .rhUnit(rhUnit), .rpGO(rpGO), .rpFUN(rpFUN), .rpDVA(rpDVA),
      .rpATA(rpATA), .rpERR(rpERR), .goReject(goReject), .goWhileBusy(goWhileBusy)
   );

endmodule

`default_nettype wire

/* rhControllerTb.sv */
// Table-driven testbench for the controller with clock, reset, stimulus loop, checks and summary
`timescale 1ns/1ps
`default_nettype none

module rhControllerTb;

   import rhPkg::*;

   typedef enum logic [2:0] {opWrite, opRead, opWaitRdy, opWaitInt, opIack, opChkInt} opT;

   // Wait limits in clock cycles
   localparam int ackLimit = 8;
   localparam int rdyLimit = 100;
   localparam int intLimit = 20;

   logic      clk = 1'b0;
   logic      rst;
   logic      devRESET;
   logic      devWRITE;
   logic      devREAD;
   logic      devHIBYTE;
   logic      devLOBYTE;
   rhRegAddrT devADDR;
   devDataT   devDATAI;
   logic      rhIACK;
   devDataT   devDATAO;
   logic      devACK;
   logic      intReq;
   rhWordT    rhCS1;

   // Stimulus table, one entry per test
   string       rowName [0:63];
   opT          rowOp [0:63];
   rhRegAddrT   rowAddr [0:63];
   logic [15:0] rowData [0:63];
   logic [1:0]  rowLanes [0:63];
   logic [15:0] rowExp [0:63];
   int          rowCount = 0;
   logic        rowOk;
   int          passCount = 0;
   int          failCount = 0;

   rhController #(
      .driveLatency(16)
   ) UUT (
      .clk(clk), .rst(rst), .devRESET(devRESET), .devWRITE(devWRITE),
      .devREAD(devREAD), .devHIBYTE(devHIBYTE), .devLOBYTE(devLOBYTE),
      .devADDR(devADDR), .devDATAI(devDATAI), .rhIACK(rhIACK),
      .devDATAO(devDATAO), .devACK(devACK), .intReq(intReq), .rhCS1(rhCS1)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   task automatic addRow(input string name, input opT op, input rhRegAddrT addr,
                         input logic [15:0] data, input logic [1:0] lanes,
                         input logic [15:0] exp);
      rowName[rowCount]  = name;
      rowOp[rowCount]    = op;
      rowAddr[rowCount]  = addr;
      rowData[rowCount]  = data;
      rowLanes[rowCount] = lanes;
      rowExp[rowCount]   = exp;
      rowCount++;
   endtask

   ////////////////////////////////////////////////////////////
   // Bus operations, all entered 1 ns after a rising edge
   ////////////////////////////////////////////////////////////

   // Write strobe for one cycle, then one idle cycle
   task automatic busWrite(input int i);
      devADDR   = rowAddr[i];
      devDATAI  = {20'b0, rowData[i]};
      devHIBYTE = rowLanes[i][1];
      devLOBYTE = rowLanes[i][0];
      devWRITE  = 1'b1;
      @(posedge clk);
      #1;
      devWRITE  = 1'b0;
      devHIBYTE = 1'b0;
      devLOBYTE = 1'b0;
      @(posedge clk);
      #1;
   endtask

   // Idle lead-in lets latched errors reach the read mux
   task automatic busRead(input int i);
      int          n;
      logic [15:0] got;
      @(posedge clk);
      #1;
      devADDR = rowAddr[i];
      devREAD = 1'b1;
      @(posedge clk);
      #1;
      devREAD = 1'b0;
      n = 0;
      while (!devACK && n < ackLimit)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!devACK)
      begin
         $display("Test %s: read was never acknowledged", rowName[i]);
         rowOk = 1'b0;
      end
      else
      begin
         got = devDATAO[20:35];
         assert (got == rowExp[i])
         else
         begin
            $display("** Error %s: expected %h, actual %h", rowName[i], rowExp[i], got);
            rowOk = 1'b0;
         end
         // CS1 port mirrors the register
         if (rowAddr[i] == rhAddrCs1)
         begin
            assert (rhCS1 == rowExp[i])
            else
            begin
               $display("** Error %s (rhCS1 port): expected %h, actual %h",
                        rowName[i], rowExp[i], rhCS1);
               rowOk = 1'b0;
            end
         end
         // Acknowledge lasts a single cycle
         @(posedge clk);
         #1;
         assert (!devACK)
         else
         begin
            $display("Test %s: acknowledge stayed high longer than one cycle", rowName[i]);
            rowOk = 1'b0;
         end
      end
   endtask

   task automatic waitReady(input int i);
      int n;
      n = 0;
      while (!rhCS1[cs1BitRdy] && n < rdyLimit)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!rhCS1[cs1BitRdy])
      begin
         $display("Test %s: timed out, drive never became ready", rowName[i]);
         rowOk = 1'b0;
      end
   endtask

   task automatic waitIntReq(input int i);
      int n;
      n = 0;
      while (!intReq && n < intLimit)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!intReq)
      begin
         $display("Test %s: timed out, no interrupt request", rowName[i]);
         rowOk = 1'b0;
      end
   endtask

   task automatic pulseIack();
      rhIACK = 1'b1;
      @(posedge clk);
      #1;
      rhIACK = 1'b0;
   endtask

   task automatic checkIntReq(input int i);
      assert (intReq == rowExp[i][0])
      else
      begin
         $display("** Error %s: expected %0d, actual %0d", rowName[i], rowExp[i][0], intReq);
         rowOk = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      integer      seed;
      integer      rnd;
      logic        ieRnd;
      logic [15:0] ieMask;
      logic [15:0] pselMask;
      int          i;

      rst       = 1'b1;
      devRESET  = 1'b0;
      devWRITE  = 1'b0;
      devREAD   = 1'b0;
      devHIBYTE = 1'b0;
      devLOBYTE = 1'b0;
      devADDR   = '0;
      devDATAI  = '0;
      rhIACK    = 1'b0;

      // Random IE and PSEL values for the byte-lane rows
      seed     = 93002;
      rnd      = $random(seed);
      ieRnd    = rnd[0];
      ieMask   = ieRnd ? 16'h0040 : 16'h0000;
      pselMask = rnd[1] ? 16'h0400 : 16'h0000;

      // Reset state, RDY and DVA only
      addRow("reset cs1", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h0880);
      addRow("reset cs2", opRead, rhAddrCs2, 16'h0000, 2'b00, 16'h0000);
      addRow("reset ba", opRead, rhAddrBa, 16'h0000, 2'b00, 16'h0000);
      addRow("reset intreq", opChkInt, rhAddrCs1, 16'h0000, 2'b00, 16'h0000);
      // Byte-lane writes, BA extension 3 via CS1 high byte
      addRow("cs1 low ie", opWrite, rhAddrCs1, ieMask, 2'b01, 16'h0000);
      addRow("cs1 high psel", opWrite, rhAddrCs1, 16'h0300 | pselMask, 2'b10, 16'h0000);
      addRow("cs1 readback", opRead, rhAddrCs1, 16'h0000, 2'b00,
             16'h0B80 | ieMask | pselMask);
      addRow("ba write", opWrite, rhAddrBa, 16'h1235, 2'b11, 16'h0000);
      addRow("ba readback", opRead, rhAddrBa, 16'h0000, 2'b00, 16'h1234);
      addRow("ba low lane", opWrite, rhAddrBa, 16'hFFFF, 2'b01, 16'h0000);
      addRow("ba low readback", opRead, rhAddrBa, 16'h0000, 2'b00, 16'h12FE);
      // Legal function 1 with IE
      addRow("go legal", opWrite, rhAddrCs1, 16'h0043, 2'b01, 16'h0000);
      addRow("busy cs1", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h0B43 | pselMask);
      addRow("wait ready", opWaitRdy, rhAddrCs1, 16'h0000, 2'b00, 16'h0000);
      addRow("wait intreq", opWaitInt, rhAddrCs1, 16'h0000, 2'b00, 16'h0000);
      addRow("done cs1", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h8BC2 | pselMask);
      addRow("iack", opIack, rhAddrCs1, 16'h0000, 2'b00, 16'h0000);
      addRow("intreq dropped", opChkInt, rhAddrCs1, 16'h0000, 2'b00, 16'h0000);
      addRow("iack clears ie", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h8B82 | pselMask);
      // Illegal function 28, composite error
      addRow("go illegal", opWrite, rhAddrCs1, 16'h0039, 2'b01, 16'h0000);
      addRow("wait illegal", opWaitRdy, rhAddrCs1, 16'h0000, 2'b00, 16'h0000);
      addRow("tre set", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'hCBB8 | pselMask);
      addRow("clear tre", opWrite, rhAddrCs1, 16'h4300 | pselMask, 2'b10, 16'h0000);
      addRow("tre cleared", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h8BB8 | pselMask);
      addRow("drive clear", opWrite, rhAddrCs1, 16'h0009, 2'b01, 16'h0000);
      addRow("sc cleared", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h0B88 | pselMask);
      // Missing unit, then GO while busy
      addRow("select unit 1", opWrite, rhAddrCs2, 16'h0001, 2'b01, 16'h0000);
      addRow("dva low", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h0388 | pselMask);
      addRow("go no drive", opWrite, rhAddrCs1, 16'h0003, 2'b01, 16'h0000);
      addRow("ned set", opRead, rhAddrCs2, 16'h0000, 2'b00, 16'h1001);
      addRow("ned tre", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'hC388 | pselMask);
      addRow("select unit 0", opWrite, rhAddrCs2, 16'h0000, 2'b01, 16'h0000);
      addRow("go start", opWrite, rhAddrCs1, 16'h0003, 2'b01, 16'h0000);
      addRow("go while busy", opWrite, rhAddrCs1, 16'h0003, 2'b01, 16'h0000);
      addRow("pge set", opRead, rhAddrCs2, 16'h0000, 2'b00, 16'h0400);
      addRow("pge tre", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'hCB03 | pselMask);
      // Controller clear aborts the busy drive
      addRow("controller clear", opWrite, rhAddrCs2, 16'h0020, 2'b01, 16'h0000);
      addRow("clear cs1", opRead, rhAddrCs1, 16'h0000, 2'b00, 16'h0880);
      addRow("clear cs2", opRead, rhAddrCs2, 16'h0000, 2'b00, 16'h0000);
      addRow("clear ba", opRead, rhAddrBa, 16'h0000, 2'b00, 16'h0000);
      addRow("final intreq", opChkInt, rhAddrCs1, 16'h0000, 2'b00, 16'h0000);

      // Reset for 8 cycles
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      for (i = 0; i < rowCount; i++)
      begin
         rowOk = 1'b1;
         case (rowOp[i])
            opWrite:   busWrite(i);
            opRead:    busRead(i);
            opWaitRdy: waitReady(i);
            opWaitInt: waitIntReq(i);
            opIack:    pulseIack();
            default:   checkIntReq(i);
         endcase
         if (rowOk)
            passCount++;
         else
            failCount++;
         $display("Test %s: %s", rowName[i], rowOk ? "ok" : "failed");
      end

      $display("Tests %0d, passed %0d, failed %0d", rowCount, passCount, failCount);
      if (failCount == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
rhPkg.sv
rhCs1.sv
rhCs2.sv
rhBa.sv
rhDrive.sv
rhUnibusSlave.sv
rhController.sv
rhControllerTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rhControllerTb
FILELIST  = sources.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
